// ==== rtl/erx_macros.svh ====
`ifndef ERX_MACROS_SVH
`define ERX_MACROS_SVH

// mesh packet width in bits
// srcaddr, data, dstaddr and ctrl
`define ERX_PW 104

// link id of this receiver
// upper 12 bits of every address that belongs to the link
// low six bits double as the column id for the continuity remap
`define ERX_ID 12'h808

// configuration window inside the link address space
// matched against dstaddr[19:16]
`define ERX_CFG_BLOCK 4'hF

// configuration register indexes
// taken from dstaddr[3:2] of a config write
`define ERX_REG_MODE    2'd0
`define ERX_REG_SEL     2'd1
`define ERX_REG_PATTERN 2'd2
`define ERX_REG_BASE    2'd3

`endif

// ==== rtl/erx_pkg.sv ====
package erx_pkg;

   // mesh packet, msb first
   typedef struct packed {
      logic [31:0] srcaddr;  // return address for reads
      logic [31:0] data;     // write data
      logic [31:0] dstaddr;  // target address, rewritten by the remap
      logic [7:0]  ctrl;     // bit 1 set for writes
   } emesh_packet_t;

   // ctrl bit that marks a write
   localparam int unsigned ctrl_write_bit = 1;

   // address translation modes
   // encoding 3 is treated like dynamic
   typedef enum logic [1:0] {
      remap_none    = 2'd0,
      remap_static  = 2'd1,
      remap_dynamic = 2'd2
   } remap_mode_t;

   // remap configuration as seen by the remap stage
   typedef struct packed {
      remap_mode_t mode;     // which translation to apply
      logic [11:0] sel;      // upper address bits to replace
      logic [11:0] pattern;  // replacement bits for static mode
      logic [31:0] base;     // offset for continuity mode
   } remap_cfg_t;

   // reset value of the configuration
   localparam remap_cfg_t remap_cfg_reset = '{
      mode:    remap_none,
      sel:     12'h000,
      pattern: 12'h000,
      base:    32'h0000_0000
   };

endpackage

// ==== rtl/erx_decode.sv ====
`timescale 1ns/1ps
`include "erx_macros.svh"

// splits incoming mesh packets into config writes and traffic
// one register stage, no back-pressure
module erx_decode (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   access_in,
   input  erx_pkg::emesh_packet_t packet_in,
   output logic                   fwd_access,
   output erx_pkg::emesh_packet_t fwd_packet,
   output logic                   cfg_write,
   output logic [1:0]             cfg_addr,
   output logic [31:0]            cfg_data
);

   logic is_write;   // packet carries a write
   logic id_match;   // upper address hits this link
   logic blk_match;  // address falls in the config window
   logic is_cfg;     // config write for this link

   assign is_write  = packet_in.ctrl[erx_pkg::ctrl_write_bit];
   assign id_match  = (packet_in.dstaddr[31:20] == `ERX_ID);
   assign blk_match = (packet_in.dstaddr[19:16] == `ERX_CFG_BLOCK);

   // reads into the window are still forwarded
   assign is_cfg = is_write & id_match & blk_match;

   // strobes, exactly one of them per packet
   always_ff @(posedge clk) begin
      if (rst) begin
         fwd_access <= 1'b0;
         cfg_write  <= 1'b0;
      end else begin
         fwd_access <= access_in & ~is_cfg;
         cfg_write  <= access_in & is_cfg;
      end
   end

   // payload follows the input every cycle
   always_ff @(posedge clk) begin
      fwd_packet <= packet_in;
      cfg_addr   <= packet_in.dstaddr[3:2];  // word index in the window
      cfg_data   <= packet_in.data;
   end

endmodule

// ==== rtl/erx_cfg.sv ====
`timescale 1ns/1ps
`include "erx_macros.svh"

// remap configuration registers
// one register updated per write strobe, new value on cfg next cycle
module erx_cfg (
   input  logic                clk,
   input  logic                rst,
   input  logic                cfg_write,
   input  logic [1:0]          cfg_addr,
   input  logic [31:0]         cfg_data,
   output erx_pkg::remap_cfg_t cfg
);

   erx_pkg::remap_mode_t mode_q;
   logic [11:0]          sel_q;
   logic [11:0]          pattern_q;
   logic [31:0]          base_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         mode_q    <= erx_pkg::remap_cfg_reset.mode;
         sel_q     <= erx_pkg::remap_cfg_reset.sel;
         pattern_q <= erx_pkg::remap_cfg_reset.pattern;
         base_q    <= erx_pkg::remap_cfg_reset.base;
      end else if (cfg_write) begin
         // each field keeps only its own width of data
         case (cfg_addr)
            `ERX_REG_MODE: begin
               mode_q <= erx_pkg::remap_mode_t'(cfg_data[1:0]);
            end
            `ERX_REG_SEL: begin
               sel_q <= cfg_data[11:0];
            end
            `ERX_REG_PATTERN: begin
               pattern_q <= cfg_data[11:0];
            end
            `ERX_REG_BASE: begin
               base_q <= cfg_data;
            end
         endcase
      end
   end

   assign cfg = '{
      mode:    mode_q,
      sel:     sel_q,
      pattern: pattern_q,
      base:    base_q
   };

endmodule

// ==== rtl/erx_remap.sv ====
`timescale 1ns/1ps
`include "erx_macros.svh"

// destination address translation
// none, static upper-bit replacement or continuity remap, registered out
module erx_remap (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   access_in,
   input  erx_pkg::emesh_packet_t packet_in,
   input  erx_pkg::remap_cfg_t    cfg,
   output logic                   access_out,
   output erx_pkg::emesh_packet_t packet_out
);

   localparam logic [11:0] link_id   = `ERX_ID;
   localparam logic [5:0]  col_id    = link_id[5:0];
   localparam int          col_shift = $clog2(col_id);  // rounded up

   logic [31:0]            addr_in;
   logic [31:0]            static_addr;
   logic [31:0]            dynamic_addr;
   logic [31:0]            col_offset;
   logic [31:0]            row_offset;
   logic [31:0]            remap_addr;
   erx_pkg::emesh_packet_t packet_next;

   assign addr_in = packet_in.dstaddr;

   // static: masked upper bits from pattern, rest untouched
   assign static_addr[31:20] = (cfg.sel & cfg.pattern) | (~cfg.sel & addr_in[31:20]);
   assign static_addr[19:0]  = addr_in[19:0];

   // continuity remap pieces
   assign col_offset = {26'd0, col_id} << 20;           // link start moved to zero
   assign row_offset = {26'd0, addr_in[31:26]} << col_shift;

   assign dynamic_addr = addr_in - col_offset + cfg.base - row_offset;

   always_comb begin
      case (cfg.mode)
         erx_pkg::remap_none:   remap_addr = addr_in;
         erx_pkg::remap_static: remap_addr = static_addr;
         default:               remap_addr = dynamic_addr;  // 2 and 3
      endcase
   end

   // only the destination changes
   always_comb begin
      packet_next         = packet_in;
      packet_next.dstaddr = remap_addr;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         access_out <= 1'b0;
      end else begin
         access_out <= access_in;
      end
   end

   always_ff @(posedge clk) begin
      packet_out <= packet_next;
   end

endmodule

// ==== rtl/erx_core.sv ====
`timescale 1ns/1ps

// receive side address translation
// decode -> cfg / remap, traffic out two cycles after its strobe
module erx_core (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   access_in,
   input  erx_pkg::emesh_packet_t packet_in,
   output logic                   access_out,
   output erx_pkg::emesh_packet_t packet_out
);

   logic                   fwd_access;
   erx_pkg::emesh_packet_t fwd_packet;
   logic                   cfg_write;
   logic [1:0]             cfg_addr;
   logic [31:0]            cfg_data;
   erx_pkg::remap_cfg_t    cfg;

   // first stage, classify and register
   erx_decode decode_i (
      .clk        (clk),
      .rst        (rst),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .fwd_access (fwd_access),
      .fwd_packet (fwd_packet),
      .cfg_write  (cfg_write),
      .cfg_addr   (cfg_addr),
      .cfg_data   (cfg_data)
   );

   // config update lands in step with the next forwarded packet
   erx_cfg cfg_i (
      .clk       (clk),
      .rst       (rst),
      .cfg_write (cfg_write),
      .cfg_addr  (cfg_addr),
      .cfg_data  (cfg_data),
      .cfg       (cfg)
   );

   erx_remap remap_i (
      .clk        (clk),
      .rst        (rst),
      .access_in  (fwd_access),
      .packet_in  (fwd_packet),
      .cfg        (cfg),
      .access_out (access_out),
      .packet_out (packet_out)
   );

endmodule

// ==== verification/erx_asserts.sv ====
`timescale 1ns/1ps

// timing and pass-through checks on erx_core, attached by bind
module erx_asserts (
   input logic                   clk,
   input logic                   rst,
   input logic                   access_in,
   input erx_pkg::emesh_packet_t packet_in,
   input logic                   cfg_write,
   input erx_pkg::remap_cfg_t    cfg,
   input logic                   access_out,
   input erx_pkg::emesh_packet_t packet_out
);

   int                     fail_count = 0;  // read by the testbench at the end
   logic                   in_d1;
   logic                   in_d2;           // input strobe two cycles back
   erx_pkg::emesh_packet_t pkt_d1;
   erx_pkg::emesh_packet_t pkt_d2;
   erx_pkg::remap_mode_t   mode_d1;         // mode the remap stage worked with

   always_ff @(posedge clk) begin
      if (rst) begin
         in_d1 <= 1'b0;
         in_d2 <= 1'b0;
      end else begin
         in_d1 <= access_in;
         in_d2 <= in_d1;
      end
   end

   always_ff @(posedge clk) begin
      pkt_d1  <= packet_in;
      pkt_d2  <= pkt_d1;
      mode_d1 <= cfg.mode;
   end

   // no output without a strobe two cycles earlier
   out_needs_strobe: assert property (@(posedge clk) disable iff (rst)
      access_out |-> in_d2)
      else begin
         $error("access_out without an input strobe two cycles earlier");
         fail_count++;
      end

   // config writes are consumed
   cfg_write_no_out: assert property (@(posedge clk) disable iff (rst)
      cfg_write |=> !access_out)
      else begin
         $error("config write produced access_out");
         fail_count++;
      end

   // traffic leaves exactly two cycles after its strobe
   strobe_to_out: assert property (@(posedge clk) disable iff (rst)
      (in_d2 && !$past(cfg_write)) |-> access_out)
      else begin
         $error("traffic strobe did not reach access_out two cycles later");
         fail_count++;
      end

   fields_kept: assert property (@(posedge clk) disable iff (rst)
      access_out |-> (packet_out.srcaddr == pkt_d2.srcaddr &&
                      packet_out.data == pkt_d2.data &&
                      packet_out.ctrl == pkt_d2.ctrl))
      else begin
         $error("srcaddr, data or ctrl changed on the way through");
         fail_count++;
      end

   none_passthrough: assert property (@(posedge clk) disable iff (rst)
      (access_out && mode_d1 == erx_pkg::remap_none) |-> packet_out == pkt_d2)
      else begin
         $error("packet changed in mode none");
         fail_count++;
      end

endmodule

bind erx_core erx_asserts asserts_i (
   .clk        (clk),
   .rst        (rst),
   .access_in  (access_in),
   .packet_in  (packet_in),
   .cfg_write  (cfg_write),
   .cfg        (cfg),
   .access_out (access_out),
   .packet_out (packet_out)
);

// ==== verification/erx_tb.sv ====
`timescale 1ns/1ps
`include "erx_macros.svh"

module erx_tb;

   localparam int          n_rand      = 20;
   localparam int          run_cycles  = 8 + 6 * (n_rand + 6);  // six tests plus reset
   localparam int          cycle_limit = 2 * run_cycles;
   localparam logic [11:0] link_id     = `ERX_ID;
   localparam int          col_id      = link_id[5:0];

   logic                   clk;
   logic                   rst;
   logic                   access_in;
   erx_pkg::emesh_packet_t packet_in;
   logic                   access_out;
   erx_pkg::emesh_packet_t packet_out;

   erx_pkg::remap_cfg_t    model_cfg;  // tracked from our own writes
   logic [31:0]            rng_state;
   int                     cycle_count;
   int                     test_errors;
   int                     mismatches;
   int                     tests_run;
   int                     tests_failed;
   int                     assert_fails;
   string                  cur_test;
   logic                   exp_v1;
   logic                   exp_v2;     // due on access_out at this falling edge
   erx_pkg::emesh_packet_t exp_p1;
   erx_pkg::emesh_packet_t exp_p2;

   erx_core dut_i (
      .clk        (clk),
      .rst        (rst),
      .access_in  (access_in),
      .packet_in  (packet_in),
      .access_out (access_out),
      .packet_out (packet_out)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("timeout: run did not end within %0d cycles", cycle_limit);
         $display("Some tests failed");
         $finish;
      end
   end

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;  // lcg
      return rng_state;
   endfunction

   function automatic int ceil_log2(input int value);
      int n;
      n = 0;
      while ((1 << n) < value) begin
         n++;
      end
      return n;
   endfunction

   // expected dstaddr for the current model configuration
   function automatic logic [31:0] model_addr(input logic [31:0] addr);
      logic [31:0] result;
      int          shift;
      result = addr;
      case (model_cfg.mode)
         erx_pkg::remap_none: begin
            result = addr;
         end
         erx_pkg::remap_static: begin
            for (int i = 0; i < 12; i++) begin
               if (model_cfg.sel[i]) result[20 + i] = model_cfg.pattern[i];
            end
         end
         default: begin
            shift  = ceil_log2(col_id);
            result = addr - (col_id << 20);
            result = result + model_cfg.base;
            result = result - (32'(addr[31:26]) << shift);
         end
      endcase
      return result;
   endfunction

   function automatic logic is_cfg_write(input erx_pkg::emesh_packet_t pkt);
      return pkt.ctrl[1] && pkt.dstaddr[31:20] == link_id &&
             pkt.dstaddr[19:16] == `ERX_CFG_BLOCK;
   endfunction

   task automatic model_write(input logic [1:0] idx, input logic [31:0] data);
      case (idx)
         2'd0: model_cfg.mode = erx_pkg::remap_mode_t'(data[1:0]);
         2'd1: model_cfg.sel = data[11:0];
         2'd2: model_cfg.pattern = data[11:0];
         default: model_cfg.base = data;
      endcase
   endtask

   function automatic erx_pkg::emesh_packet_t random_packet();
      erx_pkg::emesh_packet_t pkt;
      logic [31:0]            r;
      pkt.srcaddr = next_rand();
      pkt.data    = next_rand();
      pkt.dstaddr = next_rand();
      r           = next_rand();
      pkt.ctrl    = r[7:0];
      return pkt;
   endfunction

   task automatic check_output();
      assert (access_out == exp_v2) else begin
         $display("FAIL %s: access_out expected %0b actual %0b", cur_test, exp_v2, access_out);
         test_errors++;
      end
      if (exp_v2 && access_out) begin
         assert (packet_out == exp_p2) else begin
            $display("FAIL %s: packet expected %h actual %h", cur_test, exp_p2, packet_out);
            test_errors++;
         end
      end
   endtask

   // check outputs, then drive the next input, all on the falling edge
   task automatic step(input logic acc, input erx_pkg::emesh_packet_t pkt);
      logic                   exp_v;
      erx_pkg::emesh_packet_t exp_p;
      @(negedge clk);
      check_output();
      exp_v = 1'b0;
      exp_p = pkt;
      if (acc) begin
         if (is_cfg_write(pkt)) begin
            model_write(pkt.dstaddr[3:2], pkt.data);  // visible to the next packet
         end else begin
            exp_v         = 1'b1;
            exp_p.dstaddr = model_addr(pkt.dstaddr);
         end
      end
      exp_v2    = exp_v1;
      exp_p2    = exp_p1;
      exp_v1    = exp_v;
      exp_p1    = exp_p;
      access_in = acc;
      packet_in = pkt;
   endtask

   task automatic idle();
      step(1'b0, random_packet());  // payload must be ignored
   endtask

   task automatic write_cfg(input logic [1:0] idx, input logic [31:0] data);
      erx_pkg::emesh_packet_t pkt;
      pkt         = random_packet();
      pkt.dstaddr = {link_id, `ERX_CFG_BLOCK, 12'd0, idx, 2'b00};
      pkt.data    = data;
      pkt.ctrl[1] = 1'b1;
      step(1'b1, pkt);
   endtask

   task automatic set_mode(input logic [1:0] mode);
      logic [31:0] r;
      r = next_rand();
      write_cfg(2'd0, {r[31:2], mode});  // upper bits are junk on purpose
   endtask

   task automatic start_test(input string name);
      cur_test    = name;
      test_errors = 0;
   endtask

   task automatic end_test();
      idle();
      idle();  // drain the two pipeline stages
      tests_run++;
      mismatches += test_errors;
      if (test_errors == 0) begin
         $display("test %s: ok", cur_test);
      end else begin
         $display("test %s: %0d errors", cur_test, test_errors);
         tests_failed++;
      end
   endtask

   initial begin
      erx_pkg::emesh_packet_t pkt;
      clk          = 1'b0;
      rst          = 1'b1;
      access_in    = 1'b0;
      packet_in    = '0;
      rng_state    = 32'd71060;
      cycle_count  = 0;
      mismatches   = 0;
      tests_run    = 0;
      tests_failed = 0;
      exp_v1       = 1'b0;
      exp_v2       = 1'b0;
      exp_p1       = '0;
      exp_p2       = '0;
      model_cfg    = '{mode: erx_pkg::remap_none, sel: 12'h0, pattern: 12'h0, base: 32'h0};
      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      start_test("reset_idle");
      repeat (4) idle();
      end_test();

      start_test("passthrough");
      repeat (n_rand) step(1'b1, random_packet());
      end_test();

      // each register write shows on the packet right behind it
      start_test("cfg_write");
      set_mode(2'd2);
      step(1'b1, random_packet());
      write_cfg(2'd3, next_rand());
      step(1'b1, random_packet());
      set_mode(2'd1);
      step(1'b1, random_packet());
      write_cfg(2'd1, next_rand());
      step(1'b1, random_packet());
      write_cfg(2'd2, next_rand());
      step(1'b1, random_packet());
      end_test();

      start_test("static");
      write_cfg(2'd1, next_rand());
      write_cfg(2'd2, next_rand());
      set_mode(2'd1);
      repeat (n_rand) step(1'b1, random_packet());
      end_test();

      start_test("dynamic");
      write_cfg(2'd3, next_rand());
      set_mode(2'd2);
      for (int i = 0; i < n_rand; i++) begin
         pkt = random_packet();
         if (i % 2 == 1) pkt.dstaddr[31:20] = link_id;  // inside the link range
         if (i == n_rand / 2) set_mode(2'd3);          // encoding 3 acts as dynamic
         step(1'b1, pkt);
      end
      end_test();

      start_test("cfg_then_traffic");
      set_mode(2'd0);
      step(1'b1, random_packet());
      set_mode(2'd1);
      step(1'b1, random_packet());
      pkt                 = random_packet();
      pkt.dstaddr[31:16]  = {link_id, `ERX_CFG_BLOCK};
      pkt.ctrl[1]         = 1'b0;  // read into the window
      step(1'b1, pkt);
      end_test();

      repeat (2) @(negedge clk);  // last output still under the bound checks
      assert_fails = dut_i.asserts_i.fail_count;
      $display("tests run %0d, failed %0d, mismatches %0d, assertion failures %0d",
               tests_run, tests_failed, mismatches, assert_fails);
      if (tests_failed == 0 && assert_fails == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+rtl
rtl/erx_pkg.sv
rtl/erx_decode.sv
rtl/erx_cfg.sv
rtl/erx_remap.sv
rtl/erx_core.sv
verification/erx_asserts.sv
verification/erx_tb.sv

// ==== Makefile ====
# Verilator flow for the erx receive address translation stage

VERILATOR ?= verilator
TOP       ?= erx_tb
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= All tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

sim: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
